//--- rtl/payload_skid.sv
// ##############################
// two-entry payload skid buffer
// registered ready toward the input
// ##############################

`timescale 1ns/10ps

module payload_skid #(
    parameter int data_width = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_width-1:0] in_data,
    input  logic                  in_valid,
    input  logic                  in_last,
    input  logic                  m_pay_ready,
    output logic                  in_ready,
    output logic [data_width-1:0] m_pay_data,
    output logic                  m_pay_valid,
    output logic                  m_pay_last
);

    logic [data_width-1:0] temp_data;
    logic                  temp_valid;
    logic                  temp_last;

    logic out_valid_next;
    logic temp_valid_next;
    logic in_ready_early;
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // ready next cycle if the output drains now or nothing is held
    assign in_ready_early = m_pay_ready || (!temp_valid && !m_pay_valid);

    always_comb begin
        out_valid_next    = m_pay_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;
        if (in_ready) begin
            if (m_pay_ready || !m_pay_valid) begin
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_pay_ready) begin
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_pay_valid <= 1'b0;
            temp_valid  <= 1'b0;
            in_ready    <= 1'b0;
        end else begin
            m_pay_valid <= out_valid_next;
            temp_valid  <= temp_valid_next;
            in_ready    <= in_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_pay_data <= in_data;
            m_pay_last <= in_last;
        end else if (store_temp_to_out) begin
            m_pay_data <= temp_data;
            m_pay_last <= temp_last;
        end
        if (store_in_to_temp) begin
            temp_data <= in_data;
            temp_last <= in_last;
        end
    end

endmodule

//--- rtl/rr_arbiter.sv
// ##############################
// round-robin arbiter
// holds a one-hot grant until the
// granted slot releases it
// ##############################

`timescale 1ns/10ps

module rr_arbiter #(
    parameter int s_count = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [s_count-1:0] request,
    input  logic [s_count-1:0] release_grant,
    output logic [s_count-1:0] grant,
    output logic               grant_valid
);

    localparam int idx_w = (s_count > 1) ? $clog2(s_count) : 1;

    logic [idx_w-1:0]   last_idx;
    logic [idx_w-1:0]   pick_idx;
    logic [s_count-1:0] pick_onehot;
    logic               pick_valid;

    // search starts just above the previous winner and wraps
    always_comb begin
        int cand;
        pick_valid  = 1'b0;
        pick_idx    = '0;
        pick_onehot = '0;
        for (int i = 1; i <= s_count; i++) begin
            cand = (int'(last_idx) + i) % s_count;
            if (!pick_valid && request[cand]) begin
                pick_valid        = 1'b1;
                pick_idx          = idx_w'(cand);
                pick_onehot[cand] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            // first search after reset lands on source 0
            last_idx    <= idx_w'(s_count - 1);
        end else if (grant_valid) begin
            // only the holder can drop the grant
            if (|(release_grant & grant)) begin
                grant       <= '0;
                grant_valid <= 1'b0;
            end
        end else if (pick_valid) begin
            grant       <= pick_onehot;
            grant_valid <= 1'b1;
            last_idx    <= pick_idx;
        end
    end

endmodule

//--- rtl/source_slot.sv
// ##############################
// per-source frame tracker
// requests the bus and releases it
// once header and last beat are out
// ##############################

`timescale 1ns/10ps

module source_slot
    import udp_arb_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic granted,
    input  logic hdr_valid,
    input  logic hdr_ready,
    input  logic pay_valid,
    input  logic pay_ready,
    input  logic pay_last,
    output logic request,
    output logic release_grant,
    output logic hdr_open,
    output logic pay_open
);

    slot_state_t state;
    slot_state_t cur_state;
    slot_state_t next_state;
    logic        hdr_xfer;
    logic        last_xfer;

    assign hdr_xfer  = hdr_valid && hdr_ready;
    assign last_xfer = pay_valid && pay_ready && pay_last;

    // a fresh grant counts as open in its first cycle
    assign cur_state = (state == SLOT_IDLE && granted) ? SLOT_OPEN : state;

    assign hdr_open = granted && (cur_state == SLOT_OPEN || cur_state == SLOT_PAY_DONE);
    assign pay_open = granted && (cur_state == SLOT_OPEN || cur_state == SLOT_HDR_DONE);

    // completions can arrive in either order, or together
    always_comb begin
        next_state    = cur_state;
        release_grant = 1'b0;
        case (cur_state)
            SLOT_OPEN: begin
                if (hdr_xfer && last_xfer) begin
                    next_state    = SLOT_IDLE;
                    release_grant = 1'b1;
                end else if (hdr_xfer) begin
                    next_state = SLOT_HDR_DONE;
                end else if (last_xfer) begin
                    // short payload beat the header out
                    next_state = SLOT_PAY_DONE;
                end
            end
            SLOT_HDR_DONE: begin
                if (last_xfer) begin
                    next_state    = SLOT_IDLE;
                    release_grant = 1'b1;
                end
            end
            SLOT_PAY_DONE: begin
                if (hdr_xfer) begin
                    next_state    = SLOT_IDLE;
                    release_grant = 1'b1;
                end
            end
            default: next_state = SLOT_IDLE;
        endcase
    end

    // no request in the release cycle, so no instant re-grant
    assign request = (state == SLOT_IDLE) && !granted && hdr_valid && !release_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SLOT_IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

//--- rtl/udp_arb_mux.sv
// ##############################
// udp arbitrated multiplexer
// round-robin merge of udp frames
// from s_count sources onto one output
// ##############################

`timescale 1ns/10ps

module udp_arb_mux
    import udp_arb_pkg::*;
#(
    parameter int s_count    = 4,
    parameter int data_width = 8
) (
    input  logic                                  clk,
    input  logic                                  rst,

    // per-source frame inputs
    input  logic [s_count-1:0]                    s_hdr_valid,
    output logic [s_count-1:0]                    s_hdr_ready,
    input  logic [s_count-1:0][ip_addr_w-1:0]     s_ip_source_ip,
    input  logic [s_count-1:0][ip_addr_w-1:0]     s_ip_dest_ip,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_source_port,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_dest_port,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_length,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_checksum,
    input  logic [s_count-1:0][data_width-1:0]    s_pay_data,
    input  logic [s_count-1:0]                    s_pay_valid,
    output logic [s_count-1:0]                    s_pay_ready,
    input  logic [s_count-1:0]                    s_pay_last,

    // merged output
    output logic                                  m_hdr_valid,
    input  logic                                  m_hdr_ready,
    output logic [ip_addr_w-1:0]                  m_ip_source_ip,
    output logic [ip_addr_w-1:0]                  m_ip_dest_ip,
    output logic [udp_word_w-1:0]                 m_udp_source_port,
    output logic [udp_word_w-1:0]                 m_udp_dest_port,
    output logic [udp_word_w-1:0]                 m_udp_length,
    output logic [udp_word_w-1:0]                 m_udp_checksum,
    output logic [data_width-1:0]                 m_pay_data,
    output logic                                  m_pay_valid,
    input  logic                                  m_pay_ready,
    output logic                                  m_pay_last
);

    logic [s_count-1:0]    grant;
    logic                  grant_valid;
    logic [s_count-1:0]    request;
    logic [s_count-1:0]    release_grant;
    logic [s_count-1:0]    hdr_open;
    logic [s_count-1:0]    pay_open;
    logic [data_width-1:0] skid_data;
    logic                  skid_valid;
    logic                  skid_last;
    logic                  skid_ready;

    rr_arbiter #(
        .s_count(s_count)
    ) arb0 (
        .clk(clk),
        .rst(rst),
        .request(request),
        .release_grant(release_grant),
        .grant(grant),
        .grant_valid(grant_valid)
    );

    // one tracker per source
    for (genvar i = 0; i < s_count; i++) begin : g_slot
        source_slot slot (
            .clk(clk),
            .rst(rst),
            .granted(grant[i]),
            .hdr_valid(s_hdr_valid[i]),
            .hdr_ready(s_hdr_ready[i]),
            .pay_valid(s_pay_valid[i]),
            .pay_ready(s_pay_ready[i]),
            .pay_last(s_pay_last[i]),
            .request(request[i]),
            .release_grant(release_grant[i]),
            .hdr_open(hdr_open[i]),
            .pay_open(pay_open[i])
        );
    end

    udp_frame_select #(
        .s_count(s_count),
        .data_width(data_width)
    ) sel0 (
        .clk(clk),
        .rst(rst),
        .grant(grant),
        .grant_valid(grant_valid),
        .hdr_open(hdr_open),
        .pay_open(pay_open),
        .s_hdr_valid(s_hdr_valid),
        .s_ip_source_ip(s_ip_source_ip),
        .s_ip_dest_ip(s_ip_dest_ip),
        .s_udp_source_port(s_udp_source_port),
        .s_udp_dest_port(s_udp_dest_port),
        .s_udp_length(s_udp_length),
        .s_udp_checksum(s_udp_checksum),
        .s_pay_data(s_pay_data),
        .s_pay_valid(s_pay_valid),
        .s_pay_last(s_pay_last),
        .m_hdr_ready(m_hdr_ready),
        .skid_ready(skid_ready),
        .s_hdr_ready(s_hdr_ready),
        .s_pay_ready(s_pay_ready),
        .m_hdr_valid(m_hdr_valid),
        .m_ip_source_ip(m_ip_source_ip),
        .m_ip_dest_ip(m_ip_dest_ip),
        .m_udp_source_port(m_udp_source_port),
        .m_udp_dest_port(m_udp_dest_port),
        .m_udp_length(m_udp_length),
        .m_udp_checksum(m_udp_checksum),
        .skid_data(skid_data),
        .skid_valid(skid_valid),
        .skid_last(skid_last)
    );

    payload_skid #(
        .data_width(data_width)
    ) skid0 (
        .clk(clk),
        .rst(rst),
        .in_data(skid_data),
        .in_valid(skid_valid),
        .in_last(skid_last),
        .m_pay_ready(m_pay_ready),
        .in_ready(skid_ready),
        .m_pay_data(m_pay_data),
        .m_pay_valid(m_pay_valid),
        .m_pay_last(m_pay_last)
    );

endmodule

//--- rtl/udp_arb_pkg.sv
// ##############################
// udp arbitrated mux definitions
// field widths and the per-source
// slot state encoding
// ##############################

package udp_arb_pkg;

    // ipv4 address field
    localparam int ip_addr_w = 32;

    // udp ports, length and checksum
    localparam int udp_word_w = 16;

    // progress of one source through its granted frame
    typedef enum logic [1:0] {
        // not granted
        SLOT_IDLE     = 2'd0,
        // granted, nothing of the frame taken yet
        SLOT_OPEN     = 2'd1,
        // header taken, still waiting for the last beat
        SLOT_HDR_DONE = 2'd2,
        // last beat taken, header still pending
        SLOT_PAY_DONE = 2'd3
    } slot_state_t;

endpackage

//--- rtl/udp_frame_select.sv
// ##############################
// granted frame selector
// header into the output register,
// payload beats toward the skid
// ##############################

`timescale 1ns/10ps

module udp_frame_select
    import udp_arb_pkg::*;
#(
    parameter int s_count    = 4,
    parameter int data_width = 8
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [s_count-1:0]                    grant,
    input  logic                                  grant_valid,
    input  logic [s_count-1:0]                    hdr_open,
    input  logic [s_count-1:0]                    pay_open,
    input  logic [s_count-1:0]                    s_hdr_valid,
    input  logic [s_count-1:0][ip_addr_w-1:0]     s_ip_source_ip,
    input  logic [s_count-1:0][ip_addr_w-1:0]     s_ip_dest_ip,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_source_port,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_dest_port,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_length,
    input  logic [s_count-1:0][udp_word_w-1:0]    s_udp_checksum,
    input  logic [s_count-1:0][data_width-1:0]    s_pay_data,
    input  logic [s_count-1:0]                    s_pay_valid,
    input  logic [s_count-1:0]                    s_pay_last,
    input  logic                                  m_hdr_ready,
    input  logic                                  skid_ready,
    output logic [s_count-1:0]                    s_hdr_ready,
    output logic [s_count-1:0]                    s_pay_ready,
    output logic                                  m_hdr_valid,
    output logic [ip_addr_w-1:0]                  m_ip_source_ip,
    output logic [ip_addr_w-1:0]                  m_ip_dest_ip,
    output logic [udp_word_w-1:0]                 m_udp_source_port,
    output logic [udp_word_w-1:0]                 m_udp_dest_port,
    output logic [udp_word_w-1:0]                 m_udp_length,
    output logic [udp_word_w-1:0]                 m_udp_checksum,
    output logic [data_width-1:0]                 skid_data,
    output logic                                  skid_valid,
    output logic                                  skid_last
);

    localparam int idx_w = (s_count > 1) ? $clog2(s_count) : 1;

    logic [idx_w-1:0] grant_idx;
    logic             hdr_slot_free;
    logic             hdr_xfer;

    // one-hot grant to index
    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < s_count; i++) begin
            if (grant[i]) begin
                grant_idx = idx_w'(i);
            end
        end
    end

    // header register can take a new entry when empty or draining
    assign hdr_slot_free = grant_valid && (!m_hdr_valid || m_hdr_ready);
    assign s_hdr_ready   = grant & hdr_open & {s_count{hdr_slot_free}};
    assign hdr_xfer      = |(s_hdr_ready & s_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            m_hdr_valid <= 1'b0;
        end else if (hdr_xfer) begin
            m_hdr_valid <= 1'b1;
        end else if (m_hdr_ready) begin
            m_hdr_valid <= 1'b0;
        end
    end

    // capture the granted source's header fields
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            m_ip_source_ip    <= s_ip_source_ip[grant_idx];
            m_ip_dest_ip      <= s_ip_dest_ip[grant_idx];
            m_udp_source_port <= s_udp_source_port[grant_idx];
            m_udp_dest_port   <= s_udp_dest_port[grant_idx];
            m_udp_length      <= s_udp_length[grant_idx];
            m_udp_checksum    <= s_udp_checksum[grant_idx];
        end
    end

    // payload ready goes back to the granted source only
    assign s_pay_ready = grant & pay_open & {s_count{skid_ready && grant_valid}};

    assign skid_valid = |(s_pay_ready & s_pay_valid);
    assign skid_data  = s_pay_data[grant_idx];
    assign skid_last  = s_pay_last[grant_idx];

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the udp_arb_mux testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module udp_arb_mux_tb -f udp_arb_mux.f -o sim_udp_arb_mux \
    && ./obj_dir/sim_udp_arb_mux 2>&1 | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "test failed" sim.log && { echo "simulation FAILED"; exit 1; } \
    || grep -q "test passed" sim.log \
    || { echo "simulation ended without a result"; exit 1; }

echo "simulation PASSED"
exit 0

//--- tests/udp_arb_mux_assert.sv
// ##############################
// udp arbitrated mux assertions
// grant shape and output stability
// ##############################

`timescale 1ns/10ps

module udp_arb_mux_assert #(
    parameter int s_count    = 4,
    parameter int data_width = 8
) (
    input logic                  clk,
    input logic                  rst,
    input logic [s_count-1:0]    grant,
    input logic [s_count-1:0]    s_hdr_ready,
    input logic                  m_hdr_valid,
    input logic                  m_hdr_ready,
    input logic [31:0]           m_ip_source_ip,
    input logic [15:0]           m_udp_length,
    input logic [data_width-1:0] m_pay_data,
    input logic                  m_pay_valid,
    input logic                  m_pay_ready,
    input logic                  m_pay_last
);

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant vector has more than one bit set");

    hdr_ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(s_hdr_ready))
        else $error("more than one source sees header ready");

    // a stalled header keeps its fields
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_ip_source_ip)
            && $stable(m_udp_length))
        else $error("output header changed while stalled");

    pay_hold: assert property (@(posedge clk) disable iff (rst)
        m_pay_valid && !m_pay_ready |=> m_pay_valid && $stable(m_pay_data)
            && $stable(m_pay_last))
        else $error("output payload beat changed while stalled");

endmodule

bind udp_arb_mux udp_arb_mux_assert #(
    .s_count(s_count),
    .data_width(data_width)
) chk0 (
    .clk(clk), .rst(rst), .grant(grant), .s_hdr_ready(s_hdr_ready),
    .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready),
    .m_ip_source_ip(m_ip_source_ip), .m_udp_length(m_udp_length),
    .m_pay_data(m_pay_data), .m_pay_valid(m_pay_valid),
    .m_pay_ready(m_pay_ready), .m_pay_last(m_pay_last)
);

//--- tests/udp_arb_mux_tb.sv
// ##############################
// udp arbitrated mux testbench
// table-driven sources, random output
// back-pressure, in-order frame checker
// ##############################

`timescale 1ns/10ps

module udp_arb_mux_tb
    import udp_arb_pkg::*;
();

    localparam int s_count       = 4;
    localparam int data_width    = 8;
    localparam int n_frames      = 12;
    localparam int max_beats     = 6;
    localparam int timeout_cycles = n_frames * max_beats * 40;

    typedef struct packed {
        int                    src;
        logic [ip_addr_w-1:0]  sip;
        logic [ip_addr_w-1:0]  dip;
        logic [udp_word_w-1:0] sport;
        logic [udp_word_w-1:0] dport;
        logic [udp_word_w-1:0] ulen;
        logic [udp_word_w-1:0] csum;
        int                    plen;
        logic [data_width-1:0] base;
    } frame_t;

    logic clk = 1'b0;
    logic rst;

    logic [s_count-1:0]                 s_hdr_valid;
    logic [s_count-1:0]                 s_hdr_ready;
    logic [s_count-1:0][ip_addr_w-1:0]  s_ip_source_ip;
    logic [s_count-1:0][ip_addr_w-1:0]  s_ip_dest_ip;
    logic [s_count-1:0][udp_word_w-1:0] s_udp_source_port;
    logic [s_count-1:0][udp_word_w-1:0] s_udp_dest_port;
    logic [s_count-1:0][udp_word_w-1:0] s_udp_length;
    logic [s_count-1:0][udp_word_w-1:0] s_udp_checksum;
    logic [s_count-1:0][data_width-1:0] s_pay_data;
    logic [s_count-1:0]                 s_pay_valid;
    logic [s_count-1:0]                 s_pay_ready;
    logic [s_count-1:0]                 s_pay_last;

    logic                  m_hdr_valid;
    logic                  m_hdr_ready;
    logic [ip_addr_w-1:0]  m_ip_source_ip;
    logic [ip_addr_w-1:0]  m_ip_dest_ip;
    logic [udp_word_w-1:0] m_udp_source_port;
    logic [udp_word_w-1:0] m_udp_dest_port;
    logic [udp_word_w-1:0] m_udp_length;
    logic [udp_word_w-1:0] m_udp_checksum;
    logic [data_width-1:0] m_pay_data;
    logic                  m_pay_valid;
    logic                  m_pay_ready;
    logic                  m_pay_last;

    frame_t tbl [n_frames];
    int     exp_q [$];
    int     cur [s_count];
    int     nxt [s_count];
    bit     hdr_pend [s_count];
    int     beat [s_count];
    int     errors = 0;
    int     hdr_seen = 0;
    int     pay_frames = 0;
    int     pay_beat = 0;
    int     beats_seen = 0;
    int     beats_total = 0;
    integer seed = 32'h20df;

    udp_arb_mux #(
        .s_count(s_count),
        .data_width(data_width)
    ) dut0 (
        .clk(clk), .rst(rst),
        .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready),
        .s_ip_source_ip(s_ip_source_ip), .s_ip_dest_ip(s_ip_dest_ip),
        .s_udp_source_port(s_udp_source_port), .s_udp_dest_port(s_udp_dest_port),
        .s_udp_length(s_udp_length), .s_udp_checksum(s_udp_checksum),
        .s_pay_data(s_pay_data), .s_pay_valid(s_pay_valid),
        .s_pay_ready(s_pay_ready), .s_pay_last(s_pay_last),
        .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready),
        .m_ip_source_ip(m_ip_source_ip), .m_ip_dest_ip(m_ip_dest_ip),
        .m_udp_source_port(m_udp_source_port), .m_udp_dest_port(m_udp_dest_port),
        .m_udp_length(m_udp_length), .m_udp_checksum(m_udp_checksum),
        .m_pay_data(m_pay_data), .m_pay_valid(m_pay_valid),
        .m_pay_ready(m_pay_ready), .m_pay_last(m_pay_last)
    );

    always #2 clk = ~clk;

    // index of the k-th frame of source s in the table or -1 when none is left
    function automatic int find_entry(input int s, input int k);
        int seen;
        seen = 0;
        for (int i = 0; i < n_frames; i++) begin
            if (tbl[i].src == s) begin
                if (seen == k) return i;
                seen++;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic drive_inputs();
        frame_t f;
        for (int s = 0; s < s_count; s++) begin
            if (cur[s] >= 0) begin
                f = tbl[cur[s]];
                s_hdr_valid[s]       = hdr_pend[s];
                s_ip_source_ip[s]    = f.sip;
                s_ip_dest_ip[s]      = f.dip;
                s_udp_source_port[s] = f.sport;
                s_udp_dest_port[s]   = f.dport;
                s_udp_length[s]      = f.ulen;
                s_udp_checksum[s]    = f.csum;
                s_pay_valid[s]       = beat[s] < f.plen;
                s_pay_data[s]        = f.base + data_width'(beat[s]);
                s_pay_last[s]        = beat[s] == f.plen - 1;
            end else begin
                s_hdr_valid[s] = 1'b0;
                s_pay_valid[s] = 1'b0;
                s_pay_last[s]  = 1'b0;
            end
        end
        // headers drain slowly so short payloads often finish before their header
        m_hdr_ready = ($random(seed) & 7) == 0;
        m_pay_ready = ($random(seed) & 3) != 0;
    endtask

    task automatic sample_outputs();
        frame_t e;
        if (m_hdr_valid && m_hdr_ready) begin
            assert (hdr_seen < n_frames) else begin
                errors++;
                $display("unexpected extra header on the output");
            end
            if (hdr_seen < n_frames) begin
                e = tbl[exp_q[hdr_seen]];
                check_value("m_ip_source_ip", m_ip_source_ip, e.sip);
                check_value("m_ip_dest_ip", m_ip_dest_ip, e.dip);
                check_value("m_udp_source_port", 32'(m_udp_source_port), 32'(e.sport));
                check_value("m_udp_dest_port", 32'(m_udp_dest_port), 32'(e.dport));
                check_value("m_udp_length", 32'(m_udp_length), 32'(e.ulen));
                check_value("m_udp_checksum", 32'(m_udp_checksum), 32'(e.csum));
            end
            hdr_seen++;
        end
        if (m_pay_valid && m_pay_ready) begin
            beats_seen++;
            assert (pay_frames < n_frames) else begin
                errors++;
                $display("unexpected extra payload beat on the output");
            end
            if (pay_frames < n_frames) begin
                e = tbl[exp_q[pay_frames]];
                check_value("m_pay_data", 32'(m_pay_data), 32'(e.base + data_width'(pay_beat)));
                check_value("m_pay_last", 32'(m_pay_last), 32'(pay_beat == e.plen - 1));
                pay_beat++;
                if (pay_beat == e.plen) begin
                    pay_frames++;
                    pay_beat = 0;
                end
            end
        end
    endtask

    // move each source along its frame list from the handshakes just seen
    task automatic advance_sources();
        for (int s = 0; s < s_count; s++) begin
            if (cur[s] >= 0) begin
                if (s_hdr_valid[s] && s_hdr_ready[s]) hdr_pend[s] = 1'b0;
                if (s_pay_valid[s] && s_pay_ready[s]) beat[s]++;
                if (!hdr_pend[s] && beat[s] == tbl[cur[s]].plen) begin
                    cur[s]      = find_entry(s, nxt[s]);
                    nxt[s]++;
                    hdr_pend[s] = 1'b1;
                    beat[s]     = 0;
                end
            end
        end
    endtask

    initial begin
        // src, source ip, dest ip, sport, dport, length, checksum, beats, base
        tbl[0]  = '{0, 32'h0a000001, 32'hc0a80001, 16'h1000, 16'h0035, 16'h000c, 16'h1111, 4, 8'h10};
        tbl[1]  = '{1, 32'h0a000002, 32'hc0a80002, 16'h1001, 16'h0050, 16'h0009, 16'h2222, 1, 8'h20};
        tbl[2]  = '{2, 32'h0a000003, 32'hc0a80003, 16'h1002, 16'h01bb, 16'h000e, 16'h3333, 6, 8'h30};
        tbl[3]  = '{3, 32'h0a000004, 32'hc0a80004, 16'h1003, 16'h0044, 16'h000a, 16'h4444, 2, 8'h40};
        tbl[4]  = '{0, 32'h0a000011, 32'hc0a80011, 16'h2000, 16'h0035, 16'h0009, 16'h5555, 1, 8'h50};
        tbl[5]  = '{1, 32'h0a000012, 32'hc0a80012, 16'h2001, 16'h0050, 16'h000d, 16'h6666, 5, 8'h60};
        tbl[6]  = '{2, 32'h0a000013, 32'hc0a80013, 16'h2002, 16'h01bb, 16'h000b, 16'h7777, 3, 8'h70};
        tbl[7]  = '{3, 32'h0a000014, 32'hc0a80014, 16'h2003, 16'h0044, 16'h0009, 16'h8888, 1, 8'h80};
        tbl[8]  = '{0, 32'h0a000021, 32'hc0a80021, 16'h3000, 16'h0035, 16'h000e, 16'h9999, 6, 8'h90};
        tbl[9]  = '{1, 32'h0a000022, 32'hc0a80022, 16'h3001, 16'h0050, 16'h000a, 16'haaaa, 2, 8'ha0};
        tbl[10] = '{2, 32'h0a000023, 32'hc0a80023, 16'h3002, 16'h01bb, 16'h0009, 16'hbbbb, 1, 8'hb0};
        tbl[11] = '{3, 32'h0a000024, 32'hc0a80024, 16'h3003, 16'h0044, 16'h000c, 16'hcccc, 4, 8'hc0};

        rst = 1'b1;
        s_hdr_valid = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_udp_source_port = '0;
        s_udp_dest_port = '0;
        s_udp_length = '0;
        s_udp_checksum = '0;
        s_pay_data = '0;
        s_pay_valid = '0;
        s_pay_last = '0;
        m_hdr_ready = 1'b0;
        m_pay_ready = 1'b0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_value("m_hdr_valid", 32'(m_hdr_valid), 32'h0);
        check_value("m_pay_valid", 32'(m_pay_valid), 32'h0);
        check_value("s_hdr_ready", 32'(s_hdr_ready), 32'h0);
        check_value("s_pay_ready", 32'(s_pay_ready), 32'h0);

        // every source loaded from the start, so grants rotate 0..3
        for (int r = 0; r < 3; r++) begin
            for (int s = 0; s < s_count; s++) begin
                exp_q.push_back(find_entry(s, r));
            end
        end
        for (int i = 0; i < n_frames; i++) beats_total += tbl[i].plen;
        for (int s = 0; s < s_count; s++) begin
            cur[s]      = find_entry(s, 0);
            nxt[s]      = 1;
            hdr_pend[s] = 1'b1;
            beat[s]     = 0;
        end

        while (hdr_seen < n_frames || pay_frames < n_frames) begin
            @(negedge clk);
            drive_inputs();
            #1;
            sample_outputs();
            advance_sources();
        end
        // a few idle cycles to catch anything extra
        repeat (20) begin
            @(negedge clk);
            drive_inputs();
            #1;
            sample_outputs();
        end
        check_value("header count", 32'(hdr_seen), 32'(n_frames));
        check_value("payload beat count", 32'(beats_seen), 32'(beats_total));

        $display("errors %0d, headers %0d, beats %0d", errors, hdr_seen, beats_seen);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (16 + timeout_cycles) @(posedge clk);
        $display("timeout: frames were not all delivered in time");
        $display("errors %0d, headers %0d, beats %0d", errors, hdr_seen, beats_seen);
        $display("test failed");
        $finish;
    end

endmodule

//--- udp_arb_mux.f
rtl/udp_arb_pkg.sv
rtl/rr_arbiter.sv
rtl/source_slot.sv
rtl/udp_frame_select.sv
rtl/payload_skid.sv
rtl/udp_arb_mux.sv
tests/udp_arb_mux_assert.sv
tests/udp_arb_mux_tb.sv
